// ==== hdl/cplx_alu_pkg.sv ====
package cplx_alu_pkg;

  localparam int DATA_W    = 32;                    // Operand and result width.
  localparam int TAG_W     = 6;                     // Destination tag width.
  localparam int OPC_W     = 4;                     // Opcode width.
  localparam int FLAG_W    = 6;                     // Execution flag vector width.

  localparam int DIV_STEPS = 32;                    // One quotient bit per step.
  localparam int DIV_CNT_W = $clog2(DIV_STEPS);     // Step counter width.

  // Opcode encodings.
  localparam logic [OPC_W-1:0] OPC_MULT_L  = 4'h0;  // Signed product, low half.
  localparam logic [OPC_W-1:0] OPC_MULT_H  = 4'h1;  // Signed product, high half.
  localparam logic [OPC_W-1:0] OPC_MULTU_L = 4'h2;  // Unsigned product, low half.
  localparam logic [OPC_W-1:0] OPC_MULTU_H = 4'h3;  // Unsigned product, high half.
  localparam logic [OPC_W-1:0] OPC_DIV_L   = 4'h4;  // Signed quotient.
  localparam logic [OPC_W-1:0] OPC_DIV_H   = 4'h5;  // Signed remainder.
  localparam logic [OPC_W-1:0] OPC_DIVU_L  = 4'h6;  // Unsigned quotient.
  localparam logic [OPC_W-1:0] OPC_DIVU_H  = 4'h7;  // Unsigned remainder.
  localparam logic [OPC_W-1:0] OPC_SYSCALL = 4'h8;  // Trap, no arithmetic.
  // Codes 9 to 15 are illegal.

  // Flag bit positions.
  localparam int FLG_MISPRED = 0;                   // Never set in this lane.
  localparam int FLG_EXCEPT  = 1;                   // System call only.
  localparam int FLG_EXEC    = 2;                   // Any legal opcode.
  localparam int FLG_LOW     = 3;                   // Low-half operations.
  localparam int FLG_DEST    = 4;                   // Writes a destination.
  localparam int FLG_RSVD    = 5;                   // Reserved, zero.

  // Divider FSM states.
  localparam int DIV_ST_W = 2;
  localparam logic [DIV_ST_W-1:0] DIV_IDLE = 2'd0;  // Waiting for a divide.
  localparam logic [DIV_ST_W-1:0] DIV_RUN  = 2'd1;  // Shift-subtract steps.
  localparam logic [DIV_ST_W-1:0] DIV_FIX  = 2'd2;  // Sign correction.
  localparam logic [DIV_ST_W-1:0] DIV_DONE = 2'd3;  // Holding result for writeback.

endpackage

// ==== hdl/cplx_op_if.sv ====
// Decoded operation, decoder to one execution unit.
interface cplx_op_if import cplx_alu_pkg::*; ();
  logic              valid;      // Single-cycle strobe.
  logic [TAG_W-1:0]  tag;        // Destination tag.
  logic [DATA_W-1:0] data1;      // Source operand A.
  logic [DATA_W-1:0] data2;      // Source operand B.
  logic              is_signed;  // Signed operand mode.
  logic              high_half;  // High product or remainder.
  logic [FLAG_W-1:0] flags;      // Final flag vector.

  modport src (
    output valid, tag, data1, data2, is_signed, high_half, flags
  );

  modport unit (
    input valid, tag, data1, data2, is_signed, high_half, flags
  );
endinterface

// Unit result toward writeback.
interface cplx_res_if import cplx_alu_pkg::*; ();
  logic              valid;  // Result present.
  logic [TAG_W-1:0]  tag;    // Destination tag.
  logic [DATA_W-1:0] data;   // Result word.
  logic [FLAG_W-1:0] flags;  // Execution flags.
  logic              ack;    // Writeback took it this cycle.

  modport unit (
    output valid, tag, data, flags,
    input  ack
  );

  modport wb (
    input  valid, tag, data, flags,
    output ack
  );
endinterface

// ==== hdl/cplx_decode.sv ====
module cplx_decode import cplx_alu_pkg::*; (
  input  logic              op_valid_i,
  input  logic [OPC_W-1:0]  op_code_i,
  input  logic [TAG_W-1:0]  op_tag_i,
  input  logic [DATA_W-1:0] op_data1_i,
  input  logic [DATA_W-1:0] op_data2_i,
  input  logic              div_busy_i,
  cplx_op_if.src            mul_o,
  cplx_op_if.src            div_o
);

  logic              is_div;     // Goes to the divider.
  logic              is_signed;  // Signed multiply or divide.
  logic              high_half;  // Upper product or remainder.
  logic [FLAG_W-1:0] flags;

  always_comb begin
    flags = '0;                                   // Illegal codes keep all zero.
    case (op_code_i)
      OPC_MULT_L, OPC_MULTU_L, OPC_DIV_L, OPC_DIVU_L: begin
        flags[FLG_EXEC] = 1'b1;
        flags[FLG_LOW]  = 1'b1;
        flags[FLG_DEST] = 1'b1;
      end
      OPC_MULT_H, OPC_MULTU_H, OPC_DIV_H, OPC_DIVU_H: begin
        flags[FLG_EXEC] = 1'b1;
        flags[FLG_DEST] = 1'b1;
      end
      OPC_SYSCALL: begin
        flags[FLG_EXEC]   = 1'b1;
        flags[FLG_EXCEPT] = 1'b1;                 // Trap raised at writeback.
      end
      default: begin
        flags = '0;
      end
    endcase
  end

  assign is_div    = op_code_i inside {OPC_DIV_L, OPC_DIV_H, OPC_DIVU_L, OPC_DIVU_H};
  assign is_signed = op_code_i inside {OPC_MULT_L, OPC_MULT_H, OPC_DIV_L, OPC_DIV_H};
  assign high_half = flags[FLG_DEST] & ~flags[FLG_LOW];

  // Multiplier takes syscalls and illegal codes as passengers.
  assign mul_o.valid     = op_valid_i & ~is_div;
  assign mul_o.tag       = op_tag_i;
  assign mul_o.data1     = op_data1_i;
  assign mul_o.data2     = op_data2_i;
  assign mul_o.is_signed = is_signed;
  assign mul_o.high_half = high_half;
  assign mul_o.flags     = flags;

  // A divide issued while busy is dropped.
  assign div_o.valid     = op_valid_i & is_div & ~div_busy_i;
  assign div_o.tag       = op_tag_i;
  assign div_o.data1     = op_data1_i;
  assign div_o.data2     = op_data2_i;
  assign div_o.is_signed = is_signed;
  assign div_o.high_half = high_half;
  assign div_o.flags     = flags;

endmodule

// ==== hdl/cplx_multiplier.sv ====
module cplx_multiplier import cplx_alu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  cplx_op_if.unit  op_i,
  cplx_res_if.unit res_o
);

  logic                     arith;     // Real multiply, not a passenger.
  logic signed [DATA_W:0]   a_ext;     // Operand A, one extra sign bit.
  logic signed [DATA_W:0]   b_ext;     // Operand B, one extra sign bit.

  logic                     s1_valid;
  logic [TAG_W-1:0]         s1_tag;
  logic [FLAG_W-1:0]        s1_flags;
  logic                     s1_high;
  logic signed [DATA_W:0]   s1_a;
  logic signed [DATA_W:0]   s1_b;

  logic [2*DATA_W-1:0]      prod;      // Full 64-bit product.

  logic                     s2_valid;
  logic [TAG_W-1:0]         s2_tag;
  logic [FLAG_W-1:0]        s2_flags;
  logic [DATA_W-1:0]        s2_data;

  assign arith = op_i.flags[FLG_DEST];

  // Unsigned ops extend with zero, signed ops with the MSB.
  assign a_ext = {op_i.is_signed & op_i.data1[DATA_W-1], op_i.data1};
  assign b_ext = {op_i.is_signed & op_i.data2[DATA_W-1], op_i.data2};

  // Low 64 bits of the 33x33 signed product are exact for both modes.
  assign prod = s1_a * s1_b;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= op_i.valid;
      s2_valid <= s1_valid;
    end
  end

  // Stage 1, operand capture.
  always_ff @(posedge clk_i) begin
    s1_tag   <= op_i.tag;
    s1_flags <= op_i.flags;
    s1_high  <= op_i.high_half;
    s1_a     <= arith ? a_ext : '0;              // Passengers multiply zeros.
    s1_b     <= arith ? b_ext : '0;
  end

  // Stage 2, product and half select.
  always_ff @(posedge clk_i) begin
    s2_tag   <= s1_tag;
    s2_flags <= s1_flags;
    s2_data  <= s1_high ? prod[2*DATA_W-1:DATA_W] : prod[DATA_W-1:0];
  end

  // Writeback never stalls this path.
  assign res_o.valid = s2_valid;
  assign res_o.tag   = s2_tag;
  assign res_o.data  = s2_data;
  assign res_o.flags = s2_flags;

endmodule

// ==== hdl/cplx_divider.sv ====
module cplx_divider import cplx_alu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  cplx_op_if.unit  op_i,
  cplx_res_if.unit res_o,
  output logic     busy_o
);

  logic [DIV_ST_W-1:0]  state;
  logic [DIV_CNT_W-1:0] count;    // Steps left minus one.

  logic [DATA_W-1:0]    quo;      // Dividend out, quotient in, then result.
  logic [DATA_W-1:0]    rem;      // Partial remainder.
  logic [DATA_W-1:0]    dvsr;     // Divisor magnitude.
  logic                 neg_q;    // Negate quotient at the end.
  logic                 neg_r;    // Negate remainder at the end.
  logic                 high;     // Return remainder.
  logic [TAG_W-1:0]     tag;
  logic [FLAG_W-1:0]    flags;

  logic                 a_neg;
  logic                 b_neg;
  logic [DATA_W:0]      rem_sh;   // Remainder shifted with next dividend bit.
  logic [DATA_W:0]      diff;     // Trial subtraction.
  logic [DATA_W-1:0]    q_fix;
  logic [DATA_W-1:0]    r_fix;

  assign a_neg  = op_i.is_signed & op_i.data1[DATA_W-1];
  assign b_neg  = op_i.is_signed & op_i.data2[DATA_W-1];
  assign rem_sh = {rem, quo[DATA_W-1]};
  assign diff   = rem_sh - {1'b0, dvsr};
  assign q_fix  = neg_q ? -quo : quo;
  assign r_fix  = neg_r ? -rem : rem;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= DIV_IDLE;
      count <= '0;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (op_i.valid) begin
            state <= DIV_RUN;
            count <= DIV_CNT_W'(DIV_STEPS - 1);
          end
        end
        DIV_RUN: begin
          if (count == '0) begin
            state <= DIV_FIX;
          end else begin
            count <= count - 1'b1;
          end
        end
        DIV_FIX: begin
          state <= DIV_DONE;
        end
        default: begin
          if (res_o.ack) begin
            state <= DIV_IDLE;                    // Writeback took the result.
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (state)
      DIV_IDLE: begin
        if (op_i.valid) begin
          quo   <= a_neg ? -op_i.data1 : op_i.data1;
          dvsr  <= b_neg ? -op_i.data2 : op_i.data2;
          rem   <= '0;
          // Zero divisor keeps the all-ones quotient unsigned.
          neg_q <= (a_neg ^ b_neg) & (|op_i.data2);
          neg_r <= a_neg;                         // Remainder follows dividend.
          high  <= op_i.high_half;
          tag   <= op_i.tag;
          flags <= op_i.flags;
        end
      end
      DIV_RUN: begin
        if (!diff[DATA_W]) begin                  // Divisor fits, quotient bit 1.
          rem <= diff[DATA_W-1:0];
          quo <= {quo[DATA_W-2:0], 1'b1};
        end else begin
          rem <= rem_sh[DATA_W-1:0];
          quo <= {quo[DATA_W-2:0], 1'b0};
        end
      end
      DIV_FIX: begin
        // Min over -1 lands here as dividend and zero remainder.
        quo <= high ? r_fix : q_fix;
      end
      default: begin
        quo <= quo;                               // Hold until acked.
      end
    endcase
  end

  assign busy_o      = (state != DIV_IDLE);
  assign res_o.valid = (state == DIV_DONE);
  assign res_o.tag   = tag;
  assign res_o.data  = quo;
  assign res_o.flags = flags;

endmodule

// ==== hdl/cplx_writeback.sv ====
module cplx_writeback import cplx_alu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  cplx_res_if.wb            mul_i,
  cplx_res_if.wb            div_i,
  output logic              res_valid_o,
  output logic [TAG_W-1:0]  res_tag_o,
  output logic [DATA_W-1:0] res_data_o,
  output logic [FLAG_W-1:0] res_flags_o
);

  logic take_div;  // Divider wins only on an idle multiplier slot.

  assign take_div  = div_i.valid & ~mul_i.valid;
  assign div_i.ack = take_div;
  assign mul_i.ack = mul_i.valid;                 // Always accepted.

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= mul_i.valid | div_i.valid;
    end
  end

  // Result payload register.
  always_ff @(posedge clk_i) begin
    if (mul_i.valid) begin
      res_tag_o   <= mul_i.tag;
      res_data_o  <= mul_i.data;
      res_flags_o <= mul_i.flags;
    end else if (take_div) begin
      res_tag_o   <= div_i.tag;
      res_data_o  <= div_i.data;
      res_flags_o <= div_i.flags;
    end
  end

endmodule

// ==== hdl/cplx_alu_top.sv ====
module cplx_alu_top import cplx_alu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              op_valid_i,
  input  logic [OPC_W-1:0]  op_code_i,
  input  logic [TAG_W-1:0]  op_tag_i,
  input  logic [DATA_W-1:0] op_data1_i,
  input  logic [DATA_W-1:0] op_data2_i,
  output logic              div_busy_o,
  output logic              res_valid_o,
  output logic [TAG_W-1:0]  res_tag_o,
  output logic [DATA_W-1:0] res_data_o,
  output logic [FLAG_W-1:0] res_flags_o
);

  cplx_op_if  mul_op ();   // Decoder to multiplier.
  cplx_op_if  div_op ();   // Decoder to divider.
  cplx_res_if mul_res ();  // Multiplier to writeback.
  cplx_res_if div_res ();  // Divider to writeback.

  cplx_decode u_decode (
    .op_valid_i (op_valid_i),
    .op_code_i  (op_code_i),
    .op_tag_i   (op_tag_i),
    .op_data1_i (op_data1_i),
    .op_data2_i (op_data2_i),
    .div_busy_i (div_busy_o),
    .mul_o      (mul_op),
    .div_o      (div_op)
  );

  cplx_multiplier u_mult (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .op_i  (mul_op),
    .res_o (mul_res)
  );

  cplx_divider u_div (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .op_i   (div_op),
    .res_o  (div_res),
    .busy_o (div_busy_o)
  );

  cplx_writeback u_wb (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mul_i       (mul_res),
    .div_i       (div_res),
    .res_valid_o (res_valid_o),
    .res_tag_o   (res_tag_o),
    .res_data_o  (res_data_o),
    .res_flags_o (res_flags_o)
  );

endmodule

// ==== sim/cplx_alu_tb.sv ====
module cplx_alu_tb import cplx_alu_pkg::*; ();

  localparam int N_MUL_CORNER = 4 * 36;            // Four kinds times six by six corners.
  localparam int N_MUL_RAND   = 40;
  localparam int N_DIV_RAND   = 24;
  localparam int N_DIV_FIX    = 8;                 // Zero divisor and min over -1.
  localparam int N_MIX_DIV    = 6;
  localparam int N_MIX_CYC    = 320;               // Mixed stream length in cycles.
  localparam int N_MIX_MUL    = N_MIX_CYC - N_MIX_CYC / 8 - N_MIX_DIV;  // Mixed multiplies.
  localparam int N_MISC       = 9;                 // Syscalls and illegal codes.
  localparam int N_DIV        = N_DIV_RAND + N_DIV_FIX + N_MIX_DIV;
  localparam int N_OTHER      = N_MUL_CORNER + N_MUL_RAND + N_MIX_MUL + N_MISC;
  localparam int TIMEOUT_CYC  = 200 * N_DIV + 10 * N_OTHER;

  logic              clk_i;
  logic              rst_i;
  logic              op_valid_i;
  logic [OPC_W-1:0]  op_code_i;
  logic [TAG_W-1:0]  op_tag_i;
  logic [DATA_W-1:0] op_data1_i;
  logic [DATA_W-1:0] op_data2_i;
  logic              div_busy_o;
  logic              res_valid_o;
  logic [TAG_W-1:0]  res_tag_o;
  logic [DATA_W-1:0] res_data_o;
  logic [FLAG_W-1:0] res_flags_o;

  // Scoreboard indexed by tag.
  logic [DATA_W-1:0] exp_data  [2**TAG_W];
  logic [FLAG_W-1:0] exp_flags [2**TAG_W];
  logic              pending   [2**TAG_W];
  logic              retired   [2**TAG_W];
  logic              is_div_op [2**TAG_W];
  int                issue_cyc [2**TAG_W];

  logic [TAG_W-1:0]  next_tag;
  int                pending_cnt;
  int                checked;
  int                errors;
  int                cyc;

  logic [OPC_W-1:0]  mul_ops [4] = '{OPC_MULT_L, OPC_MULT_H, OPC_MULTU_L, OPC_MULTU_H};
  logic [OPC_W-1:0]  div_ops [4] = '{OPC_DIV_L, OPC_DIV_H, OPC_DIVU_L, OPC_DIVU_H};
  logic [DATA_W-1:0] corners [6] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                     32'h8000_0000, 32'h7fff_ffff, 32'h1234_5678};

  cplx_alu_top uut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .op_valid_i  (op_valid_i),
    .op_code_i   (op_code_i),
    .op_tag_i    (op_tag_i),
    .op_data1_i  (op_data1_i),
    .op_data2_i  (op_data2_i),
    .div_busy_o  (div_busy_o),
    .res_valid_o (res_valid_o),
    .res_tag_o   (res_tag_o),
    .res_data_o  (res_data_o),
    .res_flags_o (res_flags_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;                        // Period of 8.

  // Expected {flags, data} from the opcode rules.
  function automatic logic [FLAG_W+DATA_W-1:0] ref_alu(input logic [OPC_W-1:0]  opc,
                                                       input logic [DATA_W-1:0] a,
                                                       input logic [DATA_W-1:0] b);
    logic [FLAG_W-1:0]          f;
    logic [DATA_W-1:0]          d;
    logic signed [2*DATA_W-1:0] sp;
    logic [2*DATA_W-1:0]        up;
    logic                       ovf;
    int                         sa;
    int                         sb;
    f   = '0;
    d   = '0;
    sa  = a;
    sb  = b;
    sp  = 64'(sa) * 64'(sb);                       // Sign-extended product.
    up  = {32'h0, a} * {32'h0, b};
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (opc)
      OPC_MULT_L:  d = sp[DATA_W-1:0];
      OPC_MULT_H:  d = sp[2*DATA_W-1:DATA_W];
      OPC_MULTU_L: d = up[DATA_W-1:0];
      OPC_MULTU_H: d = up[2*DATA_W-1:DATA_W];
      OPC_DIV_L: begin
        if (b == '0) d = '1;
        else if (ovf) d = a;
        else d = 32'(sa / sb);                     // Truncates toward zero.
      end
      OPC_DIV_H: begin
        if (b == '0) d = a;
        else if (ovf) d = '0;
        else d = 32'(sa % sb);                     // Sign of the dividend.
      end
      OPC_DIVU_L: begin
        if (b == '0) d = '1;
        else d = a / b;
      end
      OPC_DIVU_H: begin
        if (b == '0) d = a;
        else d = a % b;
      end
      default: d = '0;                             // Syscall and illegal.
    endcase
    if (opc inside {OPC_MULT_L, OPC_MULTU_L, OPC_DIV_L, OPC_DIVU_L}) begin
      f[FLG_EXEC] = 1'b1;
      f[FLG_LOW]  = 1'b1;
      f[FLG_DEST] = 1'b1;
    end else if (opc inside {OPC_MULT_H, OPC_MULTU_H, OPC_DIV_H, OPC_DIVU_H}) begin
      f[FLG_EXEC] = 1'b1;
      f[FLG_DEST] = 1'b1;
    end else if (opc == OPC_SYSCALL) begin
      f[FLG_EXEC]   = 1'b1;
      f[FLG_EXCEPT] = 1'b1;
    end
    return {f, d};
  endfunction

  // Drives one strobe 1 unit after an edge.
  task automatic drive_op(input logic [OPC_W-1:0]  opc,
                          input logic [DATA_W-1:0] a,
                          input logic [DATA_W-1:0] b);
    logic [TAG_W-1:0]          t;
    logic [FLAG_W+DATA_W-1:0] e;
    t = next_tag;
    repeat (2**TAG_W) if (pending[t]) t = t + TAG_W'(1);  // Skip tags in flight.
    next_tag     = t + TAG_W'(1);
    e            = ref_alu(opc, a, b);
    exp_data[t]  = e[DATA_W-1:0];
    exp_flags[t] = e[FLAG_W+DATA_W-1:DATA_W];
    is_div_op[t] = opc inside {OPC_DIV_L, OPC_DIV_H, OPC_DIVU_L, OPC_DIVU_H};
    issue_cyc[t] = cyc;
    pending[t]   = 1'b1;
    retired[t]   = 1'b0;
    pending_cnt  = pending_cnt + 1;
    op_valid_i   = 1'b1;
    op_code_i    = opc;
    op_tag_i     = t;
    op_data1_i   = a;
    op_data2_i   = b;
    @(posedge clk_i);
    #1;
    op_valid_i   = 1'b0;
  endtask

  // Divides respect the busy status.
  task automatic issue_div(input logic [OPC_W-1:0]  opc,
                           input logic [DATA_W-1:0] a,
                           input logic [DATA_W-1:0] b);
    while (div_busy_o) begin
      @(posedge clk_i);
      #1;
    end
    drive_op(opc, a, b);
  endtask

  task automatic check_result();
    logic [TAG_W-1:0] t;
    t = res_tag_o;
    if ($isunknown(res_tag_o)) begin
      $display("Result at %0t carries an undefined tag", $time);
      errors = errors + 1;
    end else if (!pending[t]) begin
      if (retired[t]) $display("Duplicate result for tag %0d at %0t", t, $time);
      else $display("Result for tag %0d that was never issued, at %0t", t, $time);
      errors = errors + 1;
    end else begin
      if (res_data_o !== exp_data[t] || res_flags_o !== exp_flags[t]) begin
        $display("Mismatch at %0t: tag %0d data %h flags %h, expected %h flags %h",
                 $time, t, res_data_o, res_flags_o, exp_data[t], exp_flags[t]);
        errors = errors + 1;
      end
      if (!is_div_op[t] && (cyc - issue_cyc[t]) != 3) begin
        $display("Mismatch at %0t: tag %0d latency %0d, expected 3",
                 $time, t, cyc - issue_cyc[t]);
        errors = errors + 1;
      end
      if (is_div_op[t] && div_busy_o) begin
        $display("div_busy_o still high when divide tag %0d retired at %0t", t, $time);
        errors = errors + 1;
      end
      pending[t]  = 1'b0;
      retired[t]  = 1'b1;
      pending_cnt = pending_cnt - 1;
      checked     = checked + 1;
    end
  endtask

  // Compare half a cycle after the result register updates.
  always @(negedge clk_i) begin
    if (!rst_i && res_valid_o) check_result();
  end

  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (cyc == TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cyc, pending_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    int div_left;
    int drain;
    void'($urandom(32'h9aa));
    for (int t = 0; t < 2**TAG_W; t++) begin
      pending[t] = 1'b0;
      retired[t] = 1'b0;
    end
    next_tag    = '0;
    pending_cnt = 0;
    checked     = 0;
    errors      = 0;
    cyc         = 0;
    rst_i       = 1'b1;
    op_valid_i  = 1'b0;
    op_code_i   = '0;
    op_tag_i    = '0;
    op_data1_i  = '0;
    op_data2_i  = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Quiet lane after reset.
    repeat (4) begin
      if (res_valid_o !== 1'b0 || div_busy_o !== 1'b0) begin
        $display("Result valid or divider busy not low after reset, before any issue");
        errors = errors + 1;
      end
      @(posedge clk_i);
      #1;
    end

    // Back-to-back multiplies on corners then random operands.
    for (int k = 0; k < 4; k++)
      for (int i = 0; i < 6; i++)
        for (int j = 0; j < 6; j++) drive_op(mul_ops[k], corners[i], corners[j]);
    for (int i = 0; i < N_MUL_RAND; i++) drive_op(mul_ops[$urandom % 4], $urandom, $urandom);

    // Random divides with small divisors every third one.
    for (int i = 0; i < N_DIV_RAND; i++) begin
      if (i % 3 == 0) issue_div(div_ops[i % 4], $urandom, 32'($urandom % 64) - 32'd32);
      else issue_div(div_ops[i % 4], $urandom, $urandom);
    end

    // Fixed results.
    for (int k = 0; k < 4; k++) issue_div(div_ops[k], $urandom, 32'h0);
    for (int k = 0; k < 4; k++) issue_div(div_ops[k], 32'h8000_0000, 32'hffff_ffff);

    // Divides inside a multiply stream with a bubble every eighth cycle.
    div_left = N_MIX_DIV;
    for (int k = 0; k < N_MIX_CYC; k++) begin
      if (k % 8 == 7) begin
        @(posedge clk_i);
        #1;
      end else if (div_left > 0 && !div_busy_o) begin
        drive_op(div_ops[div_left % 4], $urandom, $urandom);
        div_left = div_left - 1;
      end else begin
        drive_op(mul_ops[$urandom % 4], $urandom, $urandom);
      end
    end
    if (div_left != 0) begin
      $display("Only %0d of %0d mixed divides were issued", N_MIX_DIV - div_left, N_MIX_DIV);
      errors = errors + 1;
    end

    // Syscalls and every illegal code.
    drive_op(OPC_SYSCALL, $urandom, $urandom);
    drive_op(OPC_SYSCALL, $urandom, $urandom);
    for (int c = 9; c < 16; c++) drive_op(OPC_W'(c), $urandom, $urandom);

    drain = 0;
    while (pending_cnt != 0 && drain < 400) begin
      @(posedge clk_i);
      drain = drain + 1;
    end
    repeat (8) @(posedge clk_i);                   // Catch stray results.
    for (int t = 0; t < 2**TAG_W; t++) begin
      if (pending[t]) begin
        $display("Tag %0d never retired", t);
        errors = errors + 1;
      end
    end

    $display("Summary: %0d results checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/cplx_alu_pkg.sv
hdl/cplx_op_if.sv
hdl/cplx_decode.sv
hdl/cplx_multiplier.sv
hdl/cplx_divider.sv
hdl/cplx_writeback.sv
hdl/cplx_alu_top.sv
sim/cplx_alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the lane testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module cplx_alu_tb -f filelist.f \
  -o cplx_alu_sim > build.log 2>&1 \
  && ./obj_dir/cplx_alu_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }
